/* verilog/fmau_special_pkg.sv */
// ==================================================
// Shared types for the FMA special-case judge
// Formats, rounding modes, result selects and the
// request, stage and response structs
// Imported by every module of the special pipeline
// ==================================================
`default_nettype none

package fmau_special_pkg;

  // ==================================================
  // Field widths and exponent biases
  // ==================================================
  localparam int FLEN        = 64;
  localparam int HALF_EXPN   = 5;
  localparam int HALF_FRAC   = 10;
  localparam int SINGLE_EXPN = 8;
  localparam int SINGLE_FRAC = 23;
  localparam int DOUBLE_EXPN = 11;
  localparam int DOUBLE_FRAC = 52;
  localparam int HALF_BIAS   = 15;
  localparam int SINGLE_BIAS = 127;
  localparam int DOUBLE_BIAS = 1023;
  // Signed product exponent wide enough for two double exponents
  localparam int PEXP_W      = 13;

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic [1:0] {
    FMT_HALF   = 2'd0,
    FMT_SINGLE = 2'd1,
    FMT_DOUBLE = 2'd2
  } fmt_e;

  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } rm_e;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_SRC2,
    SEL_ZERO,
    SEL_INF,
    SEL_LFN,
    SEL_CNAN,
    SEL_QNAN
  } sel_e;

  // ==================================================
  // Structs
  // ==================================================
  typedef struct packed {
    logic snan;
    logic qnan;
    logic inf;
    logic zero;
    logic norm;
  } opnd_class_t;

  typedef struct packed {
    logic            valid;
    fmt_e            fmt;
    rm_e             rm;
    logic            mac;
    logic [FLEN-1:0] src0;
    logic [FLEN-1:0] src1;
    logic [FLEN-1:0] src2;
  } fmau_req_t;

  typedef struct packed {
    logic            valid;
    fmt_e            fmt;
    sel_e            sel;
    logic            sign;
    logic [FLEN-1:0] data;
    logic            nv;
    logic            of;
  } ex2_stage_t;

  typedef struct packed {
    logic            valid;
    logic            special_vld;
    logic [FLEN-1:0] result;
    // nv in bit 1, of in bit 0
    logic [1:0]      fflags;
  } fmau_rsp_t;

endpackage

`default_nettype wire

/* verilog/fmau_operand_classify.sv */
// ==================================================
// Operand classifier for half, single and double
// Reads the fields from the low bits of the operand
// and flags sNaN, qNaN, infinity, zero or normal
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_operand_classify
  import fmau_special_pkg::*;
(
  input  wire fmt_e            fmt,
  input  wire logic [FLEN-1:0] opnd,
  output opnd_class_t          cls
);

  logic expn_ones;
  logic expn_zero;
  logic frac_zero;
  logic frac_msb;

  // Field extraction per format
  always_comb
  begin
    case (fmt)
      FMT_HALF:
      begin
        expn_ones = &opnd[HALF_EXPN+HALF_FRAC-1:HALF_FRAC];
        expn_zero = ~|opnd[HALF_EXPN+HALF_FRAC-1:HALF_FRAC];
        frac_zero = ~|opnd[HALF_FRAC-1:0];
        frac_msb  = opnd[HALF_FRAC-1];
      end
      FMT_SINGLE:
      begin
        expn_ones = &opnd[SINGLE_EXPN+SINGLE_FRAC-1:SINGLE_FRAC];
        expn_zero = ~|opnd[SINGLE_EXPN+SINGLE_FRAC-1:SINGLE_FRAC];
        frac_zero = ~|opnd[SINGLE_FRAC-1:0];
        frac_msb  = opnd[SINGLE_FRAC-1];
      end
      default:
      begin
        expn_ones = &opnd[DOUBLE_EXPN+DOUBLE_FRAC-1:DOUBLE_FRAC];
        expn_zero = ~|opnd[DOUBLE_EXPN+DOUBLE_FRAC-1:DOUBLE_FRAC];
        frac_zero = ~|opnd[DOUBLE_FRAC-1:0];
        frac_msb  = opnd[DOUBLE_FRAC-1];
      end
    endcase
  end

  // Quiet bit is the top fraction bit; subnormals fall into norm
  assign cls.snan = expn_ones && !frac_zero && !frac_msb;
  assign cls.qnan = expn_ones && frac_msb;
  assign cls.inf  = expn_ones && frac_zero;
  assign cls.zero = expn_zero && frac_zero;
  assign cls.norm = !expn_ones && !(expn_zero && frac_zero);

endmodule

`default_nettype wire

/* verilog/fmau_special_judge.sv */
// ==================================================
// EX1 special-case decision for src0 * src1 +- src2
// Classifies the operands, works out nv/of and the
// special result select, then registers it into EX2
// on every advance edge
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_special_judge
  import fmau_special_pkg::*;
(
  input  wire              fmau_ex2_data_clk,
  input  wire              rst_n,
  input  wire              advance,
  input  wire fmau_req_t   req,
  output ex2_stage_t       ex2
);

  opnd_class_t              cls0;
  opnd_class_t              cls1;
  opnd_class_t              cls2_raw;
  opnd_class_t              cls2;
  logic                     sign2;
  logic                     psign;
  logic signed [PEXP_W-1:0] pexp;
  logic signed [PEXP_W-1:0] emax;
  logic                     sub_vld;
  logic                     inf_x_zero;
  logic                     inf_prod;
  logic                     inf_sub_inf;
  logic                     any_nan;
  logic                     any_inf;
  logic                     prod_zero;
  logic                     nv;
  logic                     of;
  logic                     rnd_to_inf;
  sel_e                     sel;
  logic                     sign;
  logic [FLEN-1:0]          data;
  ex2_stage_t               ex2_d;

  function automatic logic opnd_sign(fmt_e fmt, logic [FLEN-1:0] v);
    case (fmt)
      FMT_HALF:   opnd_sign = v[HALF_EXPN+HALF_FRAC];
      FMT_SINGLE: opnd_sign = v[SINGLE_EXPN+SINGLE_FRAC];
      default:    opnd_sign = v[DOUBLE_EXPN+DOUBLE_FRAC];
    endcase
  endfunction

  // Unbiased exponent with subnormals at the minimum exponent
  function automatic logic signed [PEXP_W-1:0] opnd_expn(fmt_e fmt, logic [FLEN-1:0] v);
    logic [DOUBLE_EXPN-1:0] field;
    logic [DOUBLE_EXPN-1:0] bias;
    case (fmt)
      FMT_HALF:
      begin
        field = DOUBLE_EXPN'(v[HALF_EXPN+HALF_FRAC-1:HALF_FRAC]);
        bias  = DOUBLE_EXPN'(HALF_BIAS);
      end
      FMT_SINGLE:
      begin
        field = DOUBLE_EXPN'(v[SINGLE_EXPN+SINGLE_FRAC-1:SINGLE_FRAC]);
        bias  = DOUBLE_EXPN'(SINGLE_BIAS);
      end
      default:
      begin
        field = v[DOUBLE_EXPN+DOUBLE_FRAC-1:DOUBLE_FRAC];
        bias  = DOUBLE_EXPN'(DOUBLE_BIAS);
      end
    endcase
    if (field == '0)
      field = DOUBLE_EXPN'(1);
    opnd_expn = $signed(PEXP_W'(field)) - $signed(PEXP_W'(bias));
  endfunction

  // ==================================================
  // Operand classes
  // ==================================================
  fmau_operand_classify u_cls0 (.fmt(req.fmt), .opnd(req.src0), .cls(cls0));
  fmau_operand_classify u_cls1 (.fmt(req.fmt), .opnd(req.src1), .cls(cls1));
  fmau_operand_classify u_cls2 (.fmt(req.fmt), .opnd(req.src2), .cls(cls2_raw));

  // Plain multiply behaves as an add of zero
  assign cls2 = req.mac ? cls2_raw
                        : opnd_class_t'{snan: 1'b0, qnan: 1'b0, inf: 1'b0,
                                        zero: 1'b1, norm: 1'b0};

  // ==================================================
  // Product sign/exponent and flags
  // ==================================================
  assign sign2   = opnd_sign(req.fmt, req.src2);
  assign psign   = opnd_sign(req.fmt, req.src0) ^ opnd_sign(req.fmt, req.src1);
  assign pexp    = opnd_expn(req.fmt, req.src0) + opnd_expn(req.fmt, req.src1);
  assign sub_vld = req.mac && (psign ^ sign2);

  always_comb
  begin
    case (req.fmt)
      FMT_HALF:   emax = PEXP_W'(HALF_BIAS);
      FMT_SINGLE: emax = PEXP_W'(SINGLE_BIAS);
      default:    emax = PEXP_W'(DOUBLE_BIAS);
    endcase
  end

  assign inf_x_zero  = (cls0.inf && cls1.zero) || (cls0.zero && cls1.inf);
  assign inf_prod    = (cls0.inf && (cls1.norm || cls1.inf))
                    || (cls1.inf && (cls0.norm || cls0.inf));
  assign inf_sub_inf = inf_prod && cls2.inf && sub_vld;
  assign any_nan     = cls0.snan || cls0.qnan || cls1.snan || cls1.qnan
                    || cls2.snan || cls2.qnan;
  assign any_inf     = cls0.inf || cls1.inf || cls2.inf;
  assign prod_zero   = cls0.zero || cls1.zero;

  assign nv = cls0.snan || cls1.snan || cls2.snan || inf_x_zero || inf_sub_inf;
  assign of = cls0.norm && cls1.norm && (cls2.norm || cls2.zero) && (pexp > emax);

  // Rounding modes that push an overflow to infinity
  assign rnd_to_inf = (req.rm == RM_RNE) || (req.rm == RM_RMM)
                   || (req.rm == RM_RDN && psign)
                   || (req.rm == RM_RUP && !psign);

  // Select in priority order, first match wins
  always_comb
  begin
    sel  = SEL_NONE;
    sign = 1'b0;
    if (inf_x_zero || inf_sub_inf)
      sel = SEL_CNAN;
    else if (any_nan)
      sel = SEL_QNAN;
    else if (any_inf || (of && rnd_to_inf))
    begin
      sel  = SEL_INF;
      sign = (cls0.inf || cls1.inf || of) ? psign : sign2;
    end
    else if (of)
    begin
      sel  = SEL_LFN;
      sign = psign;
    end
    else if (prod_zero && cls2.zero)
    begin
      sel  = SEL_ZERO;
      sign = sub_vld ? (req.rm == RM_RDN) : psign;
    end
    else if (prod_zero && cls2.norm)
    begin
      sel  = SEL_SRC2;
      sign = sign2;
    end
  end

  // NaN to propagate; sNaNs win over qNaNs
  always_comb
  begin
    if (cls0.snan)
      data = req.src0;
    else if (cls1.snan)
      data = req.src1;
    else if (cls2.snan)
      data = req.src2;
    else if (cls0.qnan)
      data = req.src0;
    else if (cls1.qnan)
      data = req.src1;
    else
      data = req.src2;
  end

  // ==================================================
  // EX2 stage register
  // ==================================================
  assign ex2_d = '{valid: req.valid, fmt: req.fmt, sel: sel, sign: sign,
                   data: data, nv: nv, of: of};

  // Only the valid bit is reset
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (advance)
      ex2 <= ex2_d;
    if (!rst_n)
      ex2.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/fmau_special_result.sv */
// ==================================================
// EX2 special result assembly and output register
// Builds the selected special value in the EX2
// format, NaN-boxed to 64 bits, with nv/of flags
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_special_result
  import fmau_special_pkg::*;
(
  input  wire              fmau_ex2_data_clk,
  input  wire              rst_n,
  input  wire              advance,
  input  wire ex2_stage_t  ex2,
  output fmau_rsp_t        rsp
);

  logic [FLEN-1:0] sign_bit;
  logic [FLEN-1:0] expn_msk;
  logic [FLEN-1:0] frac_msk;
  logic [FLEN-1:0] frac_msb;
  logic [FLEN-1:0] expn_lsb;
  logic [FLEN-1:0] body_msk;
  logic [FLEN-1:0] box_msk;
  logic [FLEN-1:0] sign_fld;
  logic [FLEN-1:0] result;
  logic            special_vld;
  fmau_rsp_t       rsp_d;

  // ==================================================
  // Format masks
  // ==================================================
  always_comb
  begin
    case (ex2.fmt)
      FMT_HALF:
      begin
        sign_bit = FLEN'(1) << (HALF_EXPN + HALF_FRAC);
        expn_msk = ((FLEN'(1) << HALF_EXPN) - FLEN'(1)) << HALF_FRAC;
        frac_msk = (FLEN'(1) << HALF_FRAC) - FLEN'(1);
      end
      FMT_SINGLE:
      begin
        sign_bit = FLEN'(1) << (SINGLE_EXPN + SINGLE_FRAC);
        expn_msk = ((FLEN'(1) << SINGLE_EXPN) - FLEN'(1)) << SINGLE_FRAC;
        frac_msk = (FLEN'(1) << SINGLE_FRAC) - FLEN'(1);
      end
      default:
      begin
        sign_bit = FLEN'(1) << (DOUBLE_EXPN + DOUBLE_FRAC);
        expn_msk = ((FLEN'(1) << DOUBLE_EXPN) - FLEN'(1)) << DOUBLE_FRAC;
        frac_msk = (FLEN'(1) << DOUBLE_FRAC) - FLEN'(1);
      end
    endcase
  end

  assign expn_lsb = frac_msk + FLEN'(1);
  assign frac_msb = (frac_msk >> 1) + FLEN'(1);
  assign body_msk = sign_bit - FLEN'(1);
  // All ones above the sign bit; empty for double
  assign box_msk  = ~((sign_bit << 1) - FLEN'(1));
  assign sign_fld = ex2.sign ? sign_bit : '0;

  // ==================================================
  // Result select
  // ==================================================
  always_comb
  begin
    case (ex2.sel)
      SEL_SRC2: result = box_msk | sign_fld | (ex2.data & body_msk);
      SEL_ZERO: result = box_msk | sign_fld;
      SEL_INF:  result = box_msk | sign_fld | expn_msk;
      SEL_LFN:  result = box_msk | sign_fld | (expn_msk & ~expn_lsb) | frac_msk;
      SEL_CNAN: result = box_msk | expn_msk | frac_msb;
      // Quieted copy of the chosen NaN
      SEL_QNAN: result = box_msk | (ex2.data & ~box_msk) | frac_msb;
      default:  result = '0;
    endcase
  end

  assign special_vld = (ex2.sel != SEL_NONE);

  assign rsp_d = '{valid: ex2.valid, special_vld: special_vld, result: result,
                   fflags: {ex2.nv, ex2.of}};

  // ==================================================
  // Output stage register
  // ==================================================
  // Only the valid bit is reset
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (advance)
      rsp <= rsp_d;
    if (!rst_n)
      rsp.valid <= 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/fmau_special_top.sv */
// ==================================================
// Two-stage FMA special-case pipeline
// Request in, response out two advance edges later;
// advance low holds both stages
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_special_top
  import fmau_special_pkg::*;
(
  input  wire             fmau_ex2_data_clk,
  input  wire             rst_n,
  input  wire             advance,
  input  wire fmau_req_t  req,
  output fmau_rsp_t       rsp
);

  // EX1 to EX2 stage data
  ex2_stage_t ex2;

  fmau_special_judge u_judge (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .advance           (advance),
    .req               (req),
    .ex2               (ex2)
  );

  fmau_special_result u_result (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .advance           (advance),
    .ex2               (ex2),
    .rsp               (rsp)
  );

endmodule

`default_nettype wire

/* verification/fmau_special_checker.sv */
// ==================================================
// Response checker for the FMA special pipeline
// Queues the expected values of accepted requests,
// compares each consumed response in order and
// keeps the pass and fail counts for the testbench
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_special_checker
  import fmau_special_pkg::*;
(
  input  wire              fmau_ex2_data_clk,
  input  wire              rst_n,
  input  wire              advance,
  input  wire fmau_req_t   req,
  input  wire fmau_rsp_t   rsp,
  input  wire logic [7:0]  exp_name,
  input  wire logic        exp_vld,
  input  wire logic [63:0] exp_result,
  input  wire logic [1:0]  exp_fflags,
  output int               pass_cnt,
  output int               fail_cnt,
  output int               pending
);

  typedef struct packed {
    logic [7:0]  name;
    logic        special_vld;
    logic [63:0] result;
    logic [1:0]  fflags;
  } expect_t;

  expect_t exp_q[$];
  logic    rst_seen;
  logic    rst_bad;
  logic    rst_done;

  initial
  begin
    pass_cnt = 0;
    fail_cnt = 0;
    pending  = 0;
    rst_seen = 1'b0;
    rst_bad  = 1'b0;
    rst_done = 1'b0;
  end

  // Oldest outstanding request against the response now leaving
  task automatic check_response();
    expect_t e;
    if (exp_q.size() == 0)
    begin
      $display("Unexpected response with no request outstanding");
      fail_cnt++;
    end
    else
    begin
      e = exp_q.pop_front();
      if (rsp.special_vld === e.special_vld && rsp.result === e.result
          && rsp.fflags === e.fflags)
      begin
        pass_cnt++;
        $display("ok vec_%02h vld=%0b result=%h fflags=%b",
                 e.name, rsp.special_vld, rsp.result, rsp.fflags);
      end
      else
      begin
        fail_cnt++;
        $display("Mismatch vec_%02h expected vld=%0b res=%h ff=%b actual vld=%0b res=%h ff=%b",
                 e.name, e.special_vld, e.result, e.fflags,
                 rsp.special_vld, rsp.result, rsp.fflags);
      end
    end
  endtask

  always @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      // First reset edge clears the valid bits
      if (rst_seen && rsp.valid !== 1'b0 && !rst_bad)
      begin
        $display("Response valid is not low while reset is held");
        fail_cnt++;
        rst_bad = 1'b1;
      end
      rst_seen = 1'b1;
    end
    else
    begin
      if (rst_seen && !rst_done)
      begin
        rst_done = 1'b1;
        if (!rst_bad)
        begin
          pass_cnt++;
          $display("ok reset rsp.valid held low");
        end
      end
      // A response is consumed on each advance edge
      if (advance && rsp.valid === 1'b1)
        check_response();
      if (advance && req.valid)
        exp_q.push_back({exp_name, exp_vld, exp_result, exp_fflags});
      pending <= exp_q.size();
    end
  end

endmodule

`default_nettype wire

/* verification/fmau_special_tb.sv */
// ==================================================
// Testbench for the FMA special-case pipeline
// Reads vectors from the input file, drives them
// with random advance stalls and lets the checker
// compare every response in request order
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module fmau_special_tb
  import fmau_special_pkg::*;
();

  localparam int STALL_LIMIT = 4;
  localparam int DRAIN_LIMIT = 200;

  logic        fmau_ex2_data_clk = 1'b0;
  logic        rst_n;
  logic        advance;
  fmau_req_t   req;
  fmau_rsp_t   rsp;
  logic [7:0]  exp_name;
  logic        exp_vld;
  logic [63:0] exp_result;
  logic [1:0]  exp_fflags;
  int          pass_cnt;
  int          fail_cnt;
  int          pending;
  int          seed = 32'hebf6_d51f;

  initial
  begin
    forever #20 fmau_ex2_data_clk = ~fmau_ex2_data_clk;
  end

  fmau_special_top u_dut (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .advance           (advance),
    .req               (req),
    .rsp               (rsp)
  );

  fmau_special_checker u_chk (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .advance           (advance),
    .req               (req),
    .rsp               (rsp),
    .exp_name          (exp_name),
    .exp_vld           (exp_vld),
    .exp_result        (exp_result),
    .exp_fflags        (exp_fflags),
    .pass_cnt          (pass_cnt),
    .fail_cnt          (fail_cnt),
    .pending           (pending)
  );

  // About one edge in four stalls the pipeline
  function automatic logic pick_advance();
    pick_advance = ($random(seed) % 4) != 0;
  endfunction

  // Holds the request until an advance edge accepts it
  task automatic send_vector(input fmau_req_t r, input logic [7:0] name,
                             input logic vld, input logic [63:0] res,
                             input logic [1:0] ff);
    int stalls;
    stalls = 0;
    req        <= r;
    exp_name   <= name;
    exp_vld    <= vld;
    exp_result <= res;
    exp_fflags <= ff;
    advance    <= pick_advance();
    @(posedge fmau_ex2_data_clk);
    while (!advance && stalls < STALL_LIMIT)
    begin
      advance <= (stalls == STALL_LIMIT - 1) ? 1'b1 : pick_advance();
      stalls++;
      @(posedge fmau_ex2_data_clk);
    end
  endtask

  initial
  begin
    int          fd;
    int          n;
    int          waits;
    string       line;
    logic [7:0]  idx;
    logic [1:0]  fmt;
    logic [2:0]  rm;
    logic        mac;
    logic [63:0] src0;
    logic [63:0] src1;
    logic [63:0] src2;
    logic        evld;
    logic [63:0] eres;
    logic [1:0]  eff;
    logic        aborted;
    fmau_req_t   r;

    aborted    = 1'b0;
    fd         = 0;
    rst_n      <= 1'b0;
    advance    <= 1'b0;
    req        <= '0;
    exp_name   <= '0;
    exp_vld    <= 1'b0;
    exp_result <= '0;
    exp_fflags <= '0;
    repeat (16) @(posedge fmau_ex2_data_clk);
    rst_n <= 1'b1;

    fd = $fopen("verification/fmau_special_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file for reading");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank lines and # comments
      if (n > 1 && line.getc(0) != 8'h23)
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    idx, fmt, rm, mac, src0, src1, src2, evld, eres, eff);
        if (n != 10)
        begin
          $display("Malformed vector line: %s", line);
          aborted = 1'b1;
        end
        else
        begin
          r = '{valid: 1'b1, fmt: fmt_e'(fmt), rm: rm_e'(rm), mac: mac,
                src0: src0, src1: src1, src2: src2};
          send_vector(r, idx, evld, eres, eff);
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    req.valid <= 1'b0;

    // Drain the pipeline under random stalls
    waits = 0;
    if (!aborted)
    begin
      do
      begin
        advance <= pick_advance();
        @(posedge fmau_ex2_data_clk);
        waits++;
      end while (pending != 0 && waits < DRAIN_LIMIT);
      if (pending != 0)
      begin
        $display("Timeout: %0d responses never arrived within %0d cycles",
                 pending, DRAIN_LIMIT);
        aborted = 1'b1;
      end
    end

    // Extra edges expose duplicated responses
    advance <= 1'b1;
    repeat (4) @(posedge fmau_ex2_data_clk);
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (!aborted && fail_cnt == 0 && pass_cnt > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/fmau_special_input.txt */
# idx fmt rm mac src0 src1 src2 exp_special_vld exp_result exp_fflags, all hex
# fmt 0 half 1 single 2 double; rm 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM; fflags is {nv, of}
01 0 0 1 0000000000007d00 0000000000003c00 0000000000003c00 1 ffffffffffff7f00 2
02 0 0 1 0000000000003c00 0000000000007e05 0000000000003c00 1 ffffffffffff7e05 0
03 0 0 1 0000000000003c00 0000000000003c00 000000000000fe10 1 fffffffffffffe10 0
04 0 0 1 0000000000007e00 0000000000007c01 0000000000000000 1 ffffffffffff7e01 2
05 1 0 1 000000003f800000 000000003f800000 000000007fa00001 1 ffffffff7fe00001 2
06 1 0 1 000000007fc00010 000000003f800000 000000003f800000 1 ffffffff7fc00010 0
07 1 0 1 000000003f800000 00000000ff800001 0000000000000000 1 ffffffffffc00001 2
08 2 0 1 7ff8000000000001 7ff4000000000002 3ff0000000000000 1 7ffc000000000002 2
09 2 0 1 fff8000000000003 3ff0000000000000 7ff8000000000004 1 fff8000000000003 0
0a 2 0 1 3ff0000000000000 3ff0000000000000 7ff0000000000001 1 7ff8000000000001 2
0b 1 0 1 000000007f800000 0000000000000000 000000003f800000 1 ffffffff7fc00000 2
0c 2 0 1 7ff0000000000000 3ff0000000000000 fff0000000000000 1 7ff8000000000000 2
0d 0 0 1 000000000000fc00 0000000000003c00 0000000000003c00 1 fffffffffffffc00 0
0e 1 0 1 000000003f800000 000000003f800000 00000000ff800000 1 ffffffffff800000 0
0f 0 0 0 0000000000007800 0000000000004000 0000000000000000 1 ffffffffffff7c00 1
10 0 1 0 0000000000007800 0000000000004000 0000000000000000 1 ffffffffffff7bff 1
11 0 2 0 0000000000007800 0000000000004000 0000000000000000 1 ffffffffffff7bff 1
12 0 3 0 0000000000007800 0000000000004000 0000000000000000 1 ffffffffffff7c00 1
13 0 4 0 0000000000007800 0000000000004000 0000000000000000 1 ffffffffffff7c00 1
14 0 0 0 000000000000f800 0000000000004000 0000000000000000 1 fffffffffffffc00 1
15 0 1 0 000000000000f800 0000000000004000 0000000000000000 1 fffffffffffffbff 1
16 0 2 0 000000000000f800 0000000000004000 0000000000000000 1 fffffffffffffc00 1
17 0 3 0 000000000000f800 0000000000004000 0000000000000000 1 fffffffffffffbff 1
18 0 4 0 000000000000f800 0000000000004000 0000000000000000 1 fffffffffffffc00 1
19 1 0 1 000000007f000000 0000000040000000 000000003f800000 1 ffffffff7f800000 1
1a 2 1 0 7fe0000000000000 c000000000000000 0000000000000000 1 ffefffffffffffff 1
1b 0 2 1 0000000000000000 0000000000003c00 0000000000008000 1 ffffffffffff8000 0
1c 0 0 1 0000000000000000 0000000000003c00 0000000000008000 1 ffffffffffff0000 0
1d 1 0 1 0000000080000000 000000003f800000 0000000080000000 1 ffffffff80000000 0
1e 2 2 0 0000000000000000 bff0000000000000 0000000000000000 1 8000000000000000 0
1f 1 0 1 0000000000000000 000000003f800000 00000000c0400000 1 ffffffffc0400000 0
20 0 0 1 0000000000003c00 0000000000008000 0000000000000001 1 ffffffffffff0001 0
21 0 0 0 0000000000003c00 0000000000003c00 0000000000007d00 0 0000000000000000 0
22 2 0 1 3ff0000000000000 4000000000000000 3ff0000000000000 0 0000000000000000 0
23 1 0 1 0000000000000001 000000003f800000 000000003f800000 0 0000000000000000 0
24 0 0 1 0000000000007800 0000000000003c00 0000000000003c00 0 0000000000000000 0

/* verilog.f */
verilog/fmau_special_pkg.sv
verilog/fmau_operand_classify.sv
verilog/fmau_special_judge.sv
verilog/fmau_special_result.sv
verilog/fmau_special_top.sv
verification/fmau_special_checker.sv
verification/fmau_special_tb.sv

/* Makefile */
# Verilator build and run of the FMA special-case testbench

obj_dir/Vfmau_special_tb: verilog.f $(wildcard verilog/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing -sv -f verilog.f --top-module fmau_special_tb

run: obj_dir/Vfmau_special_tb
	@out="$$(./obj_dir/Vfmau_special_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
